// ==== Makefile ====
# Verilator simulation of the SoC control block

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_soc_ctrl \
		-f verilog.f -o tb_soc_ctrl
	./obj_dir/tb_soc_ctrl | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== rtl/apb_reg_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// APB register control
// Follows the APB phases, checks each access against the register map and
// turns legal writes into one-cycle register strobes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module apb_reg_ctrl (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // APB slave side
  input  soc_ctrl_pkg::addr_t   paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  soc_ctrl_pkg::word_t   pwdata_i,
  input  soc_ctrl_pkg::strb_t   pstrb_i,
  output soc_ctrl_pkg::word_t   prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // Register file side
  input  soc_ctrl_pkg::word_t   reg_rdata_i,
  output logic                  reg_we_o,
  output soc_ctrl_pkg::reg_idx_t reg_idx_o,
  output soc_ctrl_pkg::word_t   reg_wdata_o,
  output soc_ctrl_pkg::strb_t   reg_wstrb_o
);

  soc_ctrl_pkg::apb_state_e state_q, state_d;
  soc_ctrl_pkg::reg_off_t   reg_off;
  logic                     access_cycle;
  logic                     proper_access;
  logic                     bare_access;
  logic                     off_unaligned;
  logic                     off_out_of_range;
  logic                     ro_write;
  logic                     map_err;

  // The register map lives in the low 16 bits, upper bits are don't care
  assign reg_off = paddr_i[15:0];

  // Any cycle with psel and penable high is answered right away
  assign access_cycle  = psel_i & penable_i;
  // Only an access that directly follows a setup cycle is a real transfer
  assign proper_access = access_cycle & (state_q == soc_ctrl_pkg::APB_SETUP);
  // Penable without setup, or penable held past a completed access
  assign bare_access   = access_cycle & (state_q != soc_ctrl_pkg::APB_SETUP);

  // Next phase follows the bus directly since there are no wait states
  always_comb begin
    state_d = soc_ctrl_pkg::APB_IDLE;
    if (psel_i && !penable_i) begin
      state_d = soc_ctrl_pkg::APB_SETUP;
    end else if (proper_access) begin
      state_d = soc_ctrl_pkg::APB_ACCESS;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= soc_ctrl_pkg::APB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word alignment of the register offset
  assign off_unaligned    = (reg_off[1:0] != 2'b00);
  // Anything past the last register word is unmapped
  assign off_out_of_range = (32'(reg_off[15:2]) >= soc_ctrl_pkg::NumRegs);
  // The hardware info word is read only
  assign ro_write         = pwrite_i && (reg_off == soc_ctrl_pkg::RegOffsetHwInfo);
  assign map_err          = off_unaligned | off_out_of_range | ro_write;

  // Zero-wait-state response, also given to a bare access so the master
  // never hangs on a malformed transfer
  assign pready_o  = access_cycle;
  assign pslverr_o = bare_access | (proper_access & map_err);

  // Write strobe fires once, in the access cycle of a legal write
  assign reg_we_o    = proper_access & pwrite_i & ~map_err;
  assign reg_idx_o   = reg_off[3:2];
  assign reg_wdata_o = pwdata_i;
  assign reg_wstrb_o = pstrb_i;

  // Read data only shows during a good read access, zero at all other times
  always_comb begin
    prdata_o = '0;
    if (proper_access && !pwrite_i && !map_err) begin
      prdata_o = reg_rdata_i;
    end
  end

endmodule : apb_reg_ctrl

// ==== rtl/core_enable_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// Core enable decode
// Registered thermometer mask of the active cores
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module core_enable_decode (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  soc_ctrl_pkg::word_t      num_cores_i,
  output soc_ctrl_pkg::core_mask_t core_en_o
);

  soc_ctrl_pkg::core_mask_t core_en_d;

  // Core i runs when its index is below the count
  // The register block already keeps the count in 1..NumCores
  always_comb begin
    for (int i = 0; i < soc_ctrl_pkg::NumCores; i++) begin
      core_en_d[i] = (soc_ctrl_pkg::word_t'(i) < num_cores_i);
    end
  end

  // All cores on at reset, same as the reset value of the count
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      core_en_o <= '1;
    end else begin
      core_en_o <= core_en_d;
    end
  end

endmodule : core_enable_decode

// ==== rtl/soc_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// SoC control package
// Cluster sizes, register map offsets and shared types used by the APB
// register block and the TCDM datapath helpers
////////////////////////////////////////////////////////////////////////////

package soc_ctrl_pkg;

  // Cluster geometry
  localparam int unsigned NumCores     = 16;
  localparam int unsigned NumBanks     = 8;
  // Bank count is a power of two, so a bank index is a plain bit field
  localparam int unsigned BankIdxWidth = 3;
  localparam logic [31:0] TCDMSize     = 32'h0001_0000;

  // Register map, one 32-bit word per register
  localparam int unsigned NumRegs = 4;

  // Basic bus and datapath types
  typedef logic [31:0]             addr_t;
  typedef logic [31:0]             word_t;
  typedef logic [3:0]              strb_t;
  // Only the low half of paddr reaches the register decoder
  typedef logic [15:0]             reg_off_t;
  typedef logic [1:0]              reg_idx_t;
  typedef logic [NumCores-1:0]     core_mask_t;
  typedef logic [BankIdxWidth-1:0] bank_idx_t;
  typedef logic [31:0]             row_t;

  // Byte offsets of the four register words
  localparam reg_off_t RegOffsetTcdmStart = 16'h0000;
  localparam reg_off_t RegOffsetTcdmEnd   = 16'h0004;
  localparam reg_off_t RegOffsetNumCores  = 16'h0008;
  localparam reg_off_t RegOffsetHwInfo    = 16'h000C;

  // Read-only identification word
  // Bank count in bits 15:8 and core count in bits 7:0
  localparam word_t HwInfoValue = {16'h0000, 8'(NumBanks), 8'(NumCores)};

  // Phases of an APB transfer as seen by the slave
  typedef enum logic [1:0] {
    APB_IDLE   = 2'd0,
    APB_SETUP  = 2'd1,
    APB_ACCESS = 2'd2
  } apb_state_e;

endpackage : soc_ctrl_pkg

// ==== rtl/soc_ctrl_top.sv ====
////////////////////////////////////////////////////////////////////////////
// SoC control top
// APB register block for the cluster layout together with the TCDM
// address checker and the core enable decoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module soc_ctrl_top (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // APB slave port
  input  soc_ctrl_pkg::addr_t      paddr_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  soc_ctrl_pkg::word_t      pwdata_i,
  input  soc_ctrl_pkg::strb_t      pstrb_i,
  // Protection bits are part of the port list but carry no meaning here
  input  logic [2:0]               pprot_i,
  output soc_ctrl_pkg::word_t      prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // Current register values
  output soc_ctrl_pkg::word_t      tcdm_start_address_o,
  output soc_ctrl_pkg::word_t      tcdm_end_address_o,
  output soc_ctrl_pkg::word_t      num_cores_o,
  // Core request check
  input  logic                     req_valid_i,
  input  soc_ctrl_pkg::addr_t      req_addr_i,
  output logic                     resp_valid_o,
  output logic                     resp_hit_o,
  output soc_ctrl_pkg::bank_idx_t  resp_bank_o,
  output soc_ctrl_pkg::row_t       resp_row_o,
  // Per-core enables
  output soc_ctrl_pkg::core_mask_t core_en_o
);

  // Controller to register file
  logic                   reg_we;
  soc_ctrl_pkg::reg_idx_t reg_idx;
  soc_ctrl_pkg::word_t    reg_wdata;
  soc_ctrl_pkg::strb_t    reg_wstrb;
  soc_ctrl_pkg::word_t    reg_rdata;

  apb_reg_ctrl i_apb_reg_ctrl (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .paddr_i     ( paddr_i   ),
    .psel_i      ( psel_i    ),
    .penable_i   ( penable_i ),
    .pwrite_i    ( pwrite_i  ),
    .pwdata_i    ( pwdata_i  ),
    .pstrb_i     ( pstrb_i   ),
    .prdata_o    ( prdata_o  ),
    .pready_o    ( pready_o  ),
    .pslverr_o   ( pslverr_o ),
    .reg_rdata_i ( reg_rdata ),
    .reg_we_o    ( reg_we    ),
    .reg_idx_o   ( reg_idx   ),
    .reg_wdata_o ( reg_wdata ),
    .reg_wstrb_o ( reg_wstrb )
  );

  soc_registers i_soc_registers (
    .clk_i                ( clk_i                ),
    .arst_n_i             ( arst_n_i             ),
    .reg_we_i             ( reg_we               ),
    .reg_idx_i            ( reg_idx              ),
    .reg_wdata_i          ( reg_wdata            ),
    .reg_wstrb_i          ( reg_wstrb            ),
    .reg_rdata_o          ( reg_rdata            ),
    .tcdm_start_address_o ( tcdm_start_address_o ),
    .tcdm_end_address_o   ( tcdm_end_address_o   ),
    .num_cores_o          ( num_cores_o          )
  );

  // The checker reads the window straight from the register outputs
  tcdm_addr_check i_tcdm_addr_check (
    .clk_i                ( clk_i                ),
    .arst_n_i             ( arst_n_i             ),
    .req_valid_i          ( req_valid_i          ),
    .req_addr_i           ( req_addr_i           ),
    .tcdm_start_address_i ( tcdm_start_address_o ),
    .tcdm_end_address_i   ( tcdm_end_address_o   ),
    .resp_valid_o         ( resp_valid_o         ),
    .resp_hit_o           ( resp_hit_o           ),
    .resp_bank_o          ( resp_bank_o          ),
    .resp_row_o           ( resp_row_o           )
  );

  core_enable_decode i_core_enable_decode (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .num_cores_i ( num_cores_o ),
    .core_en_o   ( core_en_o   )
  );

endmodule : soc_ctrl_top

// ==== rtl/soc_registers.sv ====
////////////////////////////////////////////////////////////////////////////
// SoC control registers
// Holds the TCDM window and active core count with byte strobe writes,
// clamps the core count and serves the read mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module soc_registers (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   reg_we_i,
  input  soc_ctrl_pkg::reg_idx_t reg_idx_i,
  input  soc_ctrl_pkg::word_t    reg_wdata_i,
  input  soc_ctrl_pkg::strb_t    reg_wstrb_i,
  output soc_ctrl_pkg::word_t    reg_rdata_o,
  output soc_ctrl_pkg::word_t    tcdm_start_address_o,
  output soc_ctrl_pkg::word_t    tcdm_end_address_o,
  output soc_ctrl_pkg::word_t    num_cores_o
);

  soc_ctrl_pkg::word_t tcdm_start_q;
  soc_ctrl_pkg::word_t tcdm_end_q;
  soc_ctrl_pkg::word_t num_cores_q;
  soc_ctrl_pkg::word_t num_cores_merged;

  // Replaces only the bytes whose strobe bit is set
  function automatic soc_ctrl_pkg::word_t merge_bytes(
    input soc_ctrl_pkg::word_t old_val,
    input soc_ctrl_pkg::word_t new_val,
    input soc_ctrl_pkg::strb_t strb
  );
    soc_ctrl_pkg::word_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  assign num_cores_merged = merge_bytes(num_cores_q, reg_wdata_i, reg_wstrb_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tcdm_start_q <= '0;
      tcdm_end_q   <= soc_ctrl_pkg::TCDMSize;
      num_cores_q  <= soc_ctrl_pkg::word_t'(soc_ctrl_pkg::NumCores);
    end else if (reg_we_i) begin
      case (reg_idx_i)
        soc_ctrl_pkg::RegOffsetTcdmStart[3:2]:
          tcdm_start_q <= merge_bytes(tcdm_start_q, reg_wdata_i, reg_wstrb_i);
        soc_ctrl_pkg::RegOffsetTcdmEnd[3:2]:
          tcdm_end_q <= merge_bytes(tcdm_end_q, reg_wdata_i, reg_wstrb_i);
        soc_ctrl_pkg::RegOffsetNumCores[3:2]: begin
          // Clamp after the strobes so a partial write cannot leave a bad count
          if (num_cores_merged > soc_ctrl_pkg::word_t'(soc_ctrl_pkg::NumCores)) begin
            num_cores_q <= soc_ctrl_pkg::word_t'(soc_ctrl_pkg::NumCores);
          end else if (num_cores_merged == '0) begin
            num_cores_q <= 32'd1;
          end else begin
            num_cores_q <= num_cores_merged;
          end
        end
        // Hardware info is read only, the controller never strobes it
        default: ;
      endcase
    end
  end

  // Read mux, the last word is the constant hardware info
  always_comb begin
    case (reg_idx_i)
      soc_ctrl_pkg::RegOffsetTcdmStart[3:2]: reg_rdata_o = tcdm_start_q;
      soc_ctrl_pkg::RegOffsetTcdmEnd[3:2]:   reg_rdata_o = tcdm_end_q;
      soc_ctrl_pkg::RegOffsetNumCores[3:2]:  reg_rdata_o = num_cores_q;
      default:                               reg_rdata_o = soc_ctrl_pkg::HwInfoValue;
    endcase
  end

  assign tcdm_start_address_o = tcdm_start_q;
  assign tcdm_end_address_o   = tcdm_end_q;
  assign num_cores_o          = num_cores_q;

endmodule : soc_registers

// ==== rtl/tcdm_addr_check.sv ====
////////////////////////////////////////////////////////////////////////////
// TCDM address check
// Tests a core request against the TCDM window and splits the offset
// into bank and row, one register stage deep
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tcdm_addr_check (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_valid_i,
  input  soc_ctrl_pkg::addr_t     req_addr_i,
  input  soc_ctrl_pkg::addr_t     tcdm_start_address_i,
  input  soc_ctrl_pkg::addr_t     tcdm_end_address_i,
  output logic                    resp_valid_o,
  output logic                    resp_hit_o,
  output soc_ctrl_pkg::bank_idx_t resp_bank_o,
  output soc_ctrl_pkg::row_t      resp_row_o
);

  soc_ctrl_pkg::addr_t     tcdm_offset;
  logic                    in_window;
  logic                    hit_d;
  soc_ctrl_pkg::bank_idx_t bank_d;
  soc_ctrl_pkg::row_t      row_d;

  // Byte offset inside the TCDM, only meaningful on a hit
  assign tcdm_offset = req_addr_i - tcdm_start_address_i;

  // Half-open window, start included and end excluded
  assign in_window = (req_addr_i >= tcdm_start_address_i) &&
                     (req_addr_i < tcdm_end_address_i);
  assign hit_d     = req_valid_i && in_window && (req_addr_i[1:0] == 2'b00);

  // Words are interleaved across banks, so the bank is the low word index
  assign bank_d = hit_d ? tcdm_offset[2 +: soc_ctrl_pkg::BankIdxWidth] : '0;
  assign row_d  = hit_d ? (tcdm_offset >> (2 + soc_ctrl_pkg::BankIdxWidth)) : '0;

  // The valid flag is the only control bit of the stage
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= req_valid_i;
    end
  end

  // Result fields reload every cycle and read as zero without a request
  always_ff @(posedge clk_i) begin
    resp_hit_o  <= hit_d;
    resp_bank_o <= bank_d;
    resp_row_o  <= row_d;
  end

endmodule : tcdm_addr_check

// ==== verification/tb_soc_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// SoC control testbench
// Drives the APB register port and the TCDM request port and checks the
// responses against a reference model of the control registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_soc_ctrl;

  // Transaction counts of the test phases, the watchdog is sized from them
  localparam int NumRandWr      = 40;
  localparam int NumCoreVals    = 6;
  localparam int NumErrTxn      = 13;
  localparam int NumReq         = 80;
  localparam int NumTxn         = 4 + 2 * NumRandWr + 2 * NumCoreVals + NumErrTxn + 4 + NumReq;
  localparam int WatchdogCycles = (NumTxn + 8) * 20;

  typedef struct packed {
    logic                    hit;
    soc_ctrl_pkg::bank_idx_t bank;
    soc_ctrl_pkg::row_t      row;
  } resp_t;

  logic                     clk_i;
  logic                     arst_n_i;
  soc_ctrl_pkg::addr_t      paddr_i;
  logic                     psel_i;
  logic                     penable_i;
  logic                     pwrite_i;
  soc_ctrl_pkg::word_t      pwdata_i;
  soc_ctrl_pkg::strb_t      pstrb_i;
  logic [2:0]               pprot_i;
  soc_ctrl_pkg::word_t      prdata_o;
  logic                     pready_o;
  logic                     pslverr_o;
  soc_ctrl_pkg::word_t      tcdm_start_address_o;
  soc_ctrl_pkg::word_t      tcdm_end_address_o;
  soc_ctrl_pkg::word_t      num_cores_o;
  logic                     req_valid_i;
  soc_ctrl_pkg::addr_t      req_addr_i;
  logic                     resp_valid_o;
  logic                     resp_hit_o;
  soc_ctrl_pkg::bank_idx_t  resp_bank_o;
  soc_ctrl_pkg::row_t       resp_row_o;
  soc_ctrl_pkg::core_mask_t core_en_o;

  // Reference model, index is the register offset divided by four
  soc_ctrl_pkg::word_t      model_regs [4];
  soc_ctrl_pkg::core_mask_t exp_mask;
  resp_t                    resp_q [$];
  int unsigned              errors;
  int unsigned              transfers;
  int unsigned              requests;

  soc_ctrl_top UUT (.*);

  always #4 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  function automatic soc_ctrl_pkg::word_t strobe_merge(
    input soc_ctrl_pkg::word_t old_val,
    input soc_ctrl_pkg::word_t new_val,
    input soc_ctrl_pkg::strb_t strb
  );
    soc_ctrl_pkg::word_t byte_mask;
    byte_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~byte_mask) | (new_val & byte_mask);
  endfunction

  // A stored core count always lies in 1..NumCores
  function automatic soc_ctrl_pkg::word_t clamp_cores(input soc_ctrl_pkg::word_t cnt);
    if (cnt == '0) begin
      return 32'd1;
    end
    if (cnt > soc_ctrl_pkg::NumCores) begin
      return 32'(soc_ctrl_pkg::NumCores);
    end
    return cnt;
  endfunction

  function automatic soc_ctrl_pkg::core_mask_t thermometer(input soc_ctrl_pkg::word_t cnt);
    logic [32:0] wide;
    wide = (33'd1 << cnt) - 33'd1;
    return wide[soc_ctrl_pkg::NumCores-1:0];
  endfunction

  // Unaligned, unmapped and read-only writes all end in an error response
  function automatic bit map_error(input soc_ctrl_pkg::addr_t addr, input bit write);
    soc_ctrl_pkg::reg_off_t off;
    off = addr[15:0];
    return (off[1:0] != 2'b00) || (off >= 16'h0010) ||
           (write && off == soc_ctrl_pkg::RegOffsetHwInfo);
  endfunction

  function automatic soc_ctrl_pkg::word_t expected_read(input soc_ctrl_pkg::addr_t addr);
    if (map_error(addr, 1'b0)) begin
      return '0;
    end
    return model_regs[addr[3:2]];
  endfunction

  function automatic resp_t expected_resp(input soc_ctrl_pkg::addr_t addr);
    resp_t               r;
    soc_ctrl_pkg::addr_t off;
    r   = '0;
    off = addr - model_regs[0];
    if (addr >= model_regs[0] && addr < model_regs[1] && addr[1:0] == 2'b00) begin
      r.hit  = 1'b1;
      r.bank = soc_ctrl_pkg::bank_idx_t'((off / 4) % soc_ctrl_pkg::NumBanks);
      r.row  = off / (4 * soc_ctrl_pkg::NumBanks);
    end
    return r;
  endfunction

  task automatic apb_write(input soc_ctrl_pkg::addr_t addr, input soc_ctrl_pkg::word_t data,
                           input soc_ctrl_pkg::strb_t strb);
    bit         err;
    logic [1:0] idx;
    err = map_error(addr, 1'b1);
    idx = addr[3:2];
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    pstrb_i   = strb;
    @(negedge clk_i);
    penable_i = 1'b1;
    @(posedge clk_i);
    assert (pready_o && pslverr_o == err && prdata_o == '0)
      else report_error($sformatf("write %h got pready %b pslverr %b, expected 1 %b",
                                  addr, pready_o, pslverr_o, err));
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    // The register took the data at the edge that closed the access cycle
    if (!err) begin
      model_regs[idx] = strobe_merge(model_regs[idx], data, strb);
      if (idx == 2'd2) begin
        model_regs[idx] = clamp_cores(model_regs[idx]);
      end
    end
    transfers++;
  endtask

  task automatic apb_read(input soc_ctrl_pkg::addr_t addr);
    bit                  err;
    soc_ctrl_pkg::word_t exp;
    err = map_error(addr, 1'b0);
    exp = expected_read(addr);
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(negedge clk_i);
    penable_i = 1'b1;
    @(posedge clk_i);
    assert (pready_o && pslverr_o == err && prdata_o == exp)
      else report_error($sformatf("read %h got %h pslverr %b, expected %h pslverr %b",
                                  addr, prdata_o, pslverr_o, exp, err));
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    transfers++;
  endtask

  // Access cycle with no setup cycle in front of it
  task automatic bare_access(input soc_ctrl_pkg::addr_t addr, input bit write);
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b1;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = $urandom;
    pstrb_i   = 4'hF;
    @(posedge clk_i);
    assert (pready_o && pslverr_o && prdata_o == '0)
      else report_error($sformatf("bare access to %h not answered with an error", addr));
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    transfers++;
  endtask

  task automatic drive_requests(input int count);
    soc_ctrl_pkg::addr_t start;
    soc_ctrl_pkg::addr_t size;
    soc_ctrl_pkg::addr_t picks [6];
    start = model_regs[0];
    size  = model_regs[1] - model_regs[0];
    // Window edges and unaligned addresses go first
    picks = '{start, model_regs[1] - 4, model_regs[1], start + 2, start - 4, model_regs[1] + 1};
    for (int n = 0; n < count; n++) begin
      @(negedge clk_i);
      req_valid_i = 1'b1;
      if (n < 6) begin
        req_addr_i = picks[n];
      end else begin
        req_valid_i = ($urandom % 4) != 0;
        case ($urandom % 3)
          0:       req_addr_i = start + (($urandom % size) & ~32'd3);
          1:       req_addr_i = start + ($urandom % size);
          default: req_addr_i = $urandom;
        endcase
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (resp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // Zero wait states, so every cycle with psel and penable high gets pready
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   pready_o == (psel_i && penable_i))
    else report_error("pready_o differs from the APB access cycle");
  assert property (@(posedge clk_i) disable iff (!arst_n_i) pslverr_o |-> pready_o)
    else report_error("pslverr_o raised outside an access cycle");
  assert property (@(posedge clk_i) disable iff (!arst_n_i) !pready_o |-> prdata_o == '0)
    else report_error("prdata_o not zero outside an access cycle");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   resp_valid_o == $past(req_valid_i))
    else report_error("resp_valid_o does not follow req_valid_i by one cycle");

  // Register outputs, enable mask and address check results on every edge
  always @(posedge clk_i) begin : monitor
    resp_t exp_r;
    if (arst_n_i) begin
      assert ({tcdm_start_address_o, tcdm_end_address_o, num_cores_o} ==
              {model_regs[0], model_regs[1], model_regs[2]})
        else report_error($sformatf("registers %h %h %h, expected %h %h %h",
                                    tcdm_start_address_o, tcdm_end_address_o, num_cores_o,
                                    model_regs[0], model_regs[1], model_regs[2]));
      assert (core_en_o == exp_mask)
        else report_error($sformatf("core_en_o %h, expected %h", core_en_o, exp_mask));
      // The mask register follows the count one cycle later
      exp_mask = thermometer(model_regs[2]);
      if (resp_valid_o) begin
        if (resp_q.size() == 0) begin
          errors++;
          $display("A response came out at %0t with no request pending", $time);
        end else begin
          exp_r = resp_q.pop_front();
          assert ({resp_hit_o, resp_bank_o, resp_row_o} == exp_r)
            else report_error($sformatf("response %b %0d %h, expected %b %0d %h",
                                        resp_hit_o, resp_bank_o, resp_row_o,
                                        exp_r.hit, exp_r.bank, exp_r.row));
        end
      end
      if (req_valid_i) begin
        resp_q.push_back(expected_resp(req_addr_i));
        requests++;
      end
    end
  end

  initial begin
    #(WatchdogCycles * 8);
    $display("Timeout, the run did not finish within %0d clock cycles", WatchdogCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    soc_ctrl_pkg::addr_t addr;
    soc_ctrl_pkg::word_t data;
    soc_ctrl_pkg::word_t core_vals [6];
    errors      = 0;
    transfers   = 0;
    requests    = 0;
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    pstrb_i     = '0;
    pprot_i     = '0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    model_regs[0] = '0;
    model_regs[1] = soc_ctrl_pkg::TCDMSize;
    model_regs[2] = 32'(soc_ctrl_pkg::NumCores);
    model_regs[3] = {16'h0000, 8'(soc_ctrl_pkg::NumBanks), 8'(soc_ctrl_pkg::NumCores)};
    exp_mask      = '1;
    void'($urandom(32'h17a6));
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    @(posedge clk_i);
    assert (!pready_o && !pslverr_o && !resp_valid_o && prdata_o == '0 && core_en_o == '1)
      else report_error("outputs are not idle after reset");
    for (int a = 0; a < 16; a += 4) begin
      apb_read(32'(a));
    end

    // Random data and strobes, small core counts so clamping is not the rule
    for (int n = 0; n < NumRandWr; n++) begin
      addr = 32'(($urandom % 3) * 4);
      data = (addr == 32'h8) ? ($urandom % 24) : $urandom;
      apb_write(addr, data, 4'($urandom));
      apb_read(addr);
    end

    core_vals = '{32'd0, 32'd1, 32'd7, 32'd16, 32'd17, 32'hFFFF_FFFF};
    foreach (core_vals[i]) begin
      apb_write(32'h8, core_vals[i], 4'hF);
      apb_read(32'h8);
    end

    // Error responses, then bits above 15 that the decode ignores
    apb_write(32'h0000_0001, $urandom, 4'hF);
    apb_write(32'h0000_0006, $urandom, 4'hF);
    apb_write(32'h0000_0010, $urandom, 4'hF);
    apb_write(32'h0000_FFFC, $urandom, 4'hF);
    apb_write(32'h0000_000C, $urandom, 4'hF);
    apb_write(32'h0001_000C, $urandom, 4'hF);
    apb_read(32'h0000_0002);
    apb_read(32'h0000_0010);
    apb_read(32'h0000_8000);
    apb_read(32'h0000_FFF3);
    apb_write(32'hABCD_0004, $urandom, 4'hF);
    apb_read(32'h5A5A_0004);
    apb_read(32'hFFFF_000C);

    bare_access(32'h0000_0000, 1'b1);
    bare_access(32'h0000_0008, 1'b0);

    data = 32'h0000_1000 + (($urandom % 256) << 4);
    apb_write(32'h0, data, 4'hF);
    apb_write(32'h4, data + 32'h400 + (($urandom % 64) << 4), 4'hF);
    drive_requests(NumReq);

    repeat (2) @(posedge clk_i);
    $display("Transfers %0d, requests %0d, errors %0d", transfers, requests, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_soc_ctrl

// ==== verilog.f ====
rtl/soc_ctrl_pkg.sv
rtl/apb_reg_ctrl.sv
rtl/soc_registers.sv
rtl/tcdm_addr_check.sv
rtl/core_enable_decode.sv
rtl/soc_ctrl_top.sv
verification/tb_soc_ctrl.sv
